//--- common/rvIsaPkg.sv
// RV32I instruction set definitions
// Opcode classes, funct3 codes and the instruction word union
package rvIsaPkg;

   // Basic word and register index types
   typedef logic [31:0] wordT;
   typedef logic [4:0]  regIdT;

   // Instruction bits 6 to 2, one code per base class
   // SYSTEM and anything else match no class and act as a no-op
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeT;

   // Memory access size, low two bits of funct3
   // Bit 2 set means zero extension on loads
   localparam logic [2:0] f3Byte = 3'b000;
   localparam logic [2:0] f3Half = 3'b001;
   localparam logic [2:0] f3Word = 3'b010;

   // Branch conditions
   localparam logic [2:0] f3Beq  = 3'b000;
   localparam logic [2:0] f3Bne  = 3'b001;
   localparam logic [2:0] f3Blt  = 3'b100;
   localparam logic [2:0] f3Bge  = 3'b101;
   localparam logic [2:0] f3Bltu = 3'b110;
   localparam logic [2:0] f3Bgeu = 3'b111;

   // Register view, R-type field layout
   typedef struct packed {
      logic [6:0] funct7;
      regIdT      rs2;
      regIdT      rs1;
      logic [2:0] funct3;
      regIdT      rd;
      opcodeT     opcode;
      // Always 2'b11 for 32-bit encodings
      logic [1:0] quadrant;
   } rFieldsT;

   // Format view, bit groups shared by the I, S, B, U and J immediates
   typedef struct packed {
      logic       sign;
      logic [5:0] b30to25;
      logic [3:0] b24to21;
      logic       b20;
      logic [7:0] b19to12;
      logic [3:0] b11to8;
      logic       b7;
      logic [6:0] opBits;
   } fmtBitsT;

   // One instruction word, read both ways
   typedef union packed {
      rFieldsT r;
      fmtBitsT f;
   } instrU;

endpackage

//--- common/coreBusPkg.sv
// Core-level types
// Memory bus structs, sequencer states and decoded control
package coreBusPkg;

   // Core to memory
   typedef struct packed {
      rvIsaPkg::wordT addr;
      rvIsaPkg::wordT writeData;
      // Nonzero for exactly one cycle per store
      logic [3:0]     writeMask;
      logic           readStrobe;
   } memReqT;

   // Memory to core
   typedef struct packed {
      rvIsaPkg::wordT readData;
      logic           readBusy;
      logic           writeBusy;
   } memRspT;

   // One-hot sequencer states
   typedef enum logic [3:0] {
      fetchInstr = 4'b0001,
      waitInstr  = 4'b0010,
      execute    = 4'b0100,
      waitMem    = 4'b1000
   } seqStateT;

   // Decoded instruction, at most one class flag set
   typedef struct packed {
      logic            isLoad;
      logic            isAluImm;
      logic            isAuipc;
      logic            isStore;
      logic            isAluReg;
      logic            isLui;
      logic            isBranch;
      logic            isJalr;
      logic            isJal;
      // funct3Is[n] set when funct3 == n
      logic [7:0]      funct3Is;
      // Instruction bit 30
      logic            subSra;
      rvIsaPkg::regIdT rdId;
   } ctrlT;

endpackage

//--- logic/instrDecoder.sv
// Instruction decoder
// Class flags, one-hot funct3 and the five immediate formats
module instrDecoder (
   input  rvIsaPkg::instrU instr,
   output coreBusPkg::ctrlT ctrl,
   output rvIsaPkg::wordT  iImm,
   output rvIsaPkg::wordT  sImm,
   output rvIsaPkg::wordT  bImm,
   output rvIsaPkg::wordT  uImm,
   output rvIsaPkg::wordT  jImm
);
   import rvIsaPkg::*;

   // Class flags
   // Unknown opcodes leave every flag low
   assign ctrl.isLoad   = (instr.r.opcode == opLoad);
   assign ctrl.isAluImm = (instr.r.opcode == opAluImm);
   assign ctrl.isAuipc  = (instr.r.opcode == opAuipc);
   assign ctrl.isStore  = (instr.r.opcode == opStore);
   assign ctrl.isAluReg = (instr.r.opcode == opAluReg);
   assign ctrl.isLui    = (instr.r.opcode == opLui);
   assign ctrl.isBranch = (instr.r.opcode == opBranch);
   assign ctrl.isJalr   = (instr.r.opcode == opJalr);
   assign ctrl.isJal    = (instr.r.opcode == opJal);

   // funct3 in one-hot form
   // ALU op select, branch condition or access size
   assign ctrl.funct3Is = 8'b0000_0001 << instr.r.funct3;

   // Bit 30 selects SUB and SRA
   assign ctrl.subSra = instr.r.funct7[5];

   // Destination register
   assign ctrl.rdId = instr.r.rd;

   // I format
   // ALU immediates, loads and JALR
   assign iImm = {{21{instr.f.sign}}, instr.f.b30to25, instr.f.b24to21, instr.f.b20};

   // S format, offset split around rs2
   assign sImm = {{21{instr.f.sign}}, instr.f.b30to25, instr.f.b11to8, instr.f.b7};

   // B format
   // Bit 7 moves up to offset bit 11, bit 0 is always zero
   assign bImm = {
      {20{instr.f.sign}},
      instr.f.b7,
      instr.f.b30to25,
      instr.f.b11to8,
      1'b0
   };

   // U format, upper 20 bits
   assign uImm = {
      instr.f.sign,
      instr.f.b30to25,
      instr.f.b24to21,
      instr.f.b20,
      instr.f.b19to12,
      12'b0
   };

   // J format
   // 20-bit offset in halfwords, scrambled order
   assign jImm = {
      {12{instr.f.sign}},
      instr.f.b19to12,
      instr.f.b20,
      instr.f.b30to25,
      instr.f.b24to21,
      1'b0
   };

endmodule

//--- logic/regFile.sv
// Register file
// x1 to x31 storage, latched instruction and source operands
module regFile (
   input  logic            clk,
   input  logic            reset,
   input  logic            latch,
   input  rvIsaPkg::wordT  memRdata,
   input  logic            writeEn,
   input  rvIsaPkg::regIdT rdId,
   input  rvIsaPkg::wordT  writeData,
   output rvIsaPkg::instrU instr,
   output rvIsaPkg::wordT  rs1,
   output rvIsaPkg::wordT  rs2
);
   import rvIsaPkg::*;

   // x0 has no storage
   wordT  regs [1:31];
   instrU incoming;

   // Fields of the word arriving from memory
   assign incoming = memRdata;

   function automatic wordT readReg(regIdT idx);
      return (idx == '0) ? '0 : regs[idx];
   endfunction

   // Write-back, x0 writes dropped
   always_ff @(posedge clk) begin
      if (writeEn && rdId != '0) begin
         regs[rdId] <= writeData;
      end
   end

   // Operands read straight from the incoming word's fields
   // No bypass needed, write-back never shares a cycle with the latch
   always_ff @(posedge clk) begin
      if (latch) begin
         instr <= incoming;
         rs1   <= readReg(incoming.r.rs1);
         rs2   <= readReg(incoming.r.rs2);
      end
   end

   // x0 operand is zero whatever was written to x0 before
   assert property (@(posedge clk) disable iff (!reset)
      latch && incoming.r.rs1 == '0 |=> rs1 == '0);

endmodule

//--- logic/aluUnit.sv
// Integer ALU
// Add, shared subtract-compare, bit-reversed shifter, logic ops, branch test
module aluUnit (
   input  coreBusPkg::ctrlT ctrl,
   input  rvIsaPkg::wordT   rs1,
   input  rvIsaPkg::wordT   rs2,
   input  rvIsaPkg::wordT   iImm,
   output rvIsaPkg::wordT   aluOut,
   output rvIsaPkg::wordT   aluSum,
   output logic             predicate
);
   import rvIsaPkg::*;

   wordT               aluIn2;
   logic [32:0]        aluMinus;
   logic               lt;
   logic               ltu;
   logic               eq;
   logic               isSub;
   wordT               shiftIn;
   logic signed [32:0] shifted;
   wordT               rightShift;
   wordT               leftShift;

   // Second operand
   // rs2 for register ops and branches, immediate otherwise
   assign aluIn2 = (ctrl.isAluReg | ctrl.isBranch) ? rs2 : iImm;

   // Also the JALR target
   assign aluSum = rs1 + aluIn2;

   // One 33-bit subtract for SUB and every compare
   // Top bit is the unsigned borrow
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   // Differing signs decide directly
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == '0);

   // SUB exists only in register form, ADDI reuses bit 30 as immediate
   assign isSub = ctrl.isAluReg & ctrl.subSra;

   // Left shift as a right shift of the reversed word
   assign shiftIn = ctrl.funct3Is[1] ? {<<{rs1}} : rs1;

   // Extra top bit carries the sign fill for SRA
   assign shifted    = $signed({ctrl.subSra & rs1[31], shiftIn}) >>> aluIn2[4:0];
   assign rightShift = shifted[31:0];
   assign leftShift  = {<<{rightShift}};

   // Result select by one-hot funct3
   assign aluOut =
      (ctrl.funct3Is[0] ? (isSub ? aluMinus[31:0] : aluSum) : 32'b0) |
      (ctrl.funct3Is[1] ? leftShift                         : 32'b0) |
      (ctrl.funct3Is[2] ? {31'b0, lt}                       : 32'b0) |
      (ctrl.funct3Is[3] ? {31'b0, ltu}                      : 32'b0) |
      (ctrl.funct3Is[4] ? rs1 ^ aluIn2                      : 32'b0) |
      (ctrl.funct3Is[5] ? rightShift                        : 32'b0) |
      (ctrl.funct3Is[6] ? rs1 | aluIn2                      : 32'b0) |
      (ctrl.funct3Is[7] ? rs1 & aluIn2                      : 32'b0);

   // Branch condition
   // funct3 2 and 3 are not branches and never taken
   assign predicate =
      (ctrl.funct3Is[f3Beq]  &  eq)  |
      (ctrl.funct3Is[f3Bne]  & !eq)  |
      (ctrl.funct3Is[f3Blt]  &  lt)  |
      (ctrl.funct3Is[f3Bge]  & !lt)  |
      (ctrl.funct3Is[f3Bltu] &  ltu) |
      (ctrl.funct3Is[f3Bgeu] & !ltu);

endmodule

//--- logic/loadStoreUnit.sv
// Load/store datapath
// Address adder, load lane extraction and store lane replication with mask
module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  coreBusPkg::ctrlT ctrl,
   input  rvIsaPkg::wordT   rs1,
   input  rvIsaPkg::wordT   rs2,
   input  rvIsaPkg::wordT   iImm,
   input  rvIsaPkg::wordT   sImm,
   input  rvIsaPkg::wordT   memRdata,
   output rvIsaPkg::wordT   lsAddr,
   output rvIsaPkg::wordT   storeData,
   output logic [3:0]       storeMask,
   output rvIsaPkg::wordT   loadData
);
   import rvIsaPkg::*;

   logic [addrWidth-1:0] addrLow;
   logic                 byteAccess;
   logic                 halfAccess;
   logic                 loadSign;
   logic [15:0]          loadHalf;
   logic [7:0]           loadByte;

   // Own adder, offset in S format for stores
   assign addrLow = rs1[addrWidth-1:0] +
                    (ctrl.isStore ? sImm[addrWidth-1:0] : iImm[addrWidth-1:0]);
   assign lsAddr  = wordT'(addrLow);

   // Size from funct3, signed and unsigned forms alike
   assign byteAccess = ctrl.funct3Is[f3Byte] | ctrl.funct3Is[f3Byte | 3'b100];
   assign halfAccess = ctrl.funct3Is[f3Half] | ctrl.funct3Is[f3Half | 3'b100];

   // Halfword by address bit 1, then byte by bit 0
   assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3 bit 2 clear means sign extension
   assign loadSign = ~|ctrl.funct3Is[7:4] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                     memRdata;

   // Low bytes of rs2 copied into every lane they may land in
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = addrLow[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = addrLow[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = addrLow[0] ? rs2[7:0] :
                             addrLow[1] ? rs2[15:8] : rs2[31:24];

   // Lane mask, the sequencer gates it to the execute cycle
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow[1:0];
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         // Reserved sizes write nothing
         storeMask = ctrl.funct3Is[f3Word] ? 4'b1111 : 4'b0000;
      end
   end

endmodule

//--- core/coreSequencer.sv
// Instruction sequencer
// One-hot FSM, program counter, next-PC select and bus strobes
module coreSequencer #(
   parameter logic [31:0] resetAddr = 32'h0,
   parameter int          addrWidth = 24
) (
   input  logic              clk,
   input  logic              reset,
   input  coreBusPkg::ctrlT  ctrl,
   input  logic              predicate,
   input  rvIsaPkg::wordT    aluSum,
   input  rvIsaPkg::wordT    bImm,
   input  rvIsaPkg::wordT    jImm,
   input  rvIsaPkg::wordT    uImm,
   input  coreBusPkg::memRspT memRsp,
   input  rvIsaPkg::wordT    lsAddr,
   output logic              latch,
   output logic              writeEn,
   output rvIsaPkg::wordT    pcPlusImm,
   output rvIsaPkg::wordT    pcPlus4,
   output rvIsaPkg::wordT    memAddr,
   output logic              readStrobe,
   output logic              storeActive
);
   import rvIsaPkg::*;
   import coreBusPkg::*;

   seqStateT             state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcNext4;
   logic [addrWidth-1:0] pcTarget;
   logic [addrWidth-1:0] pcNew;
   logic                 writesRd;

   // Shared adder for branch, JAL and AUIPC
   assign pcNext4  = pc + addrWidth'(4);
   assign pcTarget = pc + (ctrl.isJal   ? jImm[addrWidth-1:0] :
                           ctrl.isAuipc ? uImm[addrWidth-1:0] :
                           bImm[addrWidth-1:0]);
   assign pcPlus4   = wordT'(pcNext4);
   assign pcPlusImm = wordT'(pcTarget);

   // JALR clears bit 0 of rs1 + imm
   assign pcNew = ctrl.isJalr                      ? {aluSum[addrWidth-1:1], 1'b0} :
                  (ctrl.isJal | (ctrl.isBranch & predicate)) ? pcTarget :
                  pcNext4;

   // PC on the bus while fetching, load/store address otherwise
   assign memAddr = (state == fetchInstr || state == waitInstr) ? wordT'(pc) : lsAddr;

   assign latch       = (state == waitInstr) & ~memRsp.readBusy;
   assign readStrobe  = (state == fetchInstr) | ((state == execute) & ctrl.isLoad);
   assign storeActive = (state == execute) & ctrl.isStore;

   // Only classes with a destination, so no-op opcodes write nothing
   assign writesRd = ctrl.isLoad | ctrl.isAluImm | ctrl.isAluReg | ctrl.isAuipc |
                     ctrl.isLui | ctrl.isJal | ctrl.isJalr;
   // Load data settles in the last waitMem cycle
   assign writeEn  = writesRd & ((state == execute) | (state == waitMem));

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by draining any pending write
         state <= waitMem;
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         unique case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRsp.readBusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNew;
               state <= (ctrl.isLoad | ctrl.isStore) ? waitMem : fetchInstr;
            end
            waitMem: begin
               if (!memRsp.readBusy && !memRsp.writeBusy) begin
                  state <= fetchInstr;
               end
            end
            default: state <= waitMem;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state));

   // No new request while a memory access is pending
   assert property (@(posedge clk) disable iff (!reset)
      state == waitMem |-> !readStrobe && !storeActive);

endmodule

//--- core/femtoCore.sv
// RV32I multi-cycle core, top level
// Unit instances, write-back select and memory bus drive
module femtoCore #(
   parameter logic [31:0] resetAddr = 32'h0,
   parameter int          addrWidth = 24
) (
   input  logic               clk,
   input  logic               reset,
   output coreBusPkg::memReqT memReq,
   input  coreBusPkg::memRspT memRsp
);
   import rvIsaPkg::*;
   import coreBusPkg::*;

   instrU      instr;
   ctrlT       ctrl;
   wordT       iImm;
   wordT       sImm;
   wordT       bImm;
   wordT       uImm;
   wordT       jImm;
   wordT       rs1;
   wordT       rs2;
   wordT       aluOut;
   wordT       aluSum;
   logic       predicate;
   wordT       lsAddr;
   wordT       storeData;
   logic [3:0] storeMask;
   wordT       loadData;
   logic       latch;
   logic       writeEn;
   wordT       pcPlusImm;
   wordT       pcPlus4;
   wordT       memAddr;
   logic       readStrobe;
   logic       storeActive;
   wordT       writeData;

   instrDecoder decoder (
      .instr(instr), .ctrl(ctrl),
      .iImm(iImm), .sImm(sImm), .bImm(bImm), .uImm(uImm), .jImm(jImm)
   );

   regFile registers (
      .clk(clk), .reset(reset), .latch(latch), .memRdata(memRsp.readData),
      .writeEn(writeEn), .rdId(ctrl.rdId), .writeData(writeData),
      .instr(instr), .rs1(rs1), .rs2(rs2)
   );

   aluUnit alu (
      .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .iImm(iImm),
      .aluOut(aluOut), .aluSum(aluSum), .predicate(predicate)
   );

   loadStoreUnit #(.addrWidth(addrWidth)) lsu (
      .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .iImm(iImm), .sImm(sImm),
      .memRdata(memRsp.readData), .lsAddr(lsAddr), .storeData(storeData),
      .storeMask(storeMask), .loadData(loadData)
   );

   coreSequencer #(.resetAddr(resetAddr), .addrWidth(addrWidth)) sequencer (
      .clk(clk), .reset(reset), .ctrl(ctrl), .predicate(predicate), .aluSum(aluSum),
      .bImm(bImm), .jImm(jImm), .uImm(uImm), .memRsp(memRsp), .lsAddr(lsAddr),
      .latch(latch), .writeEn(writeEn), .pcPlusImm(pcPlusImm), .pcPlus4(pcPlus4),
      .memAddr(memAddr), .readStrobe(readStrobe), .storeActive(storeActive)
   );

   // Write-back value, at most one class flag is set
   assign writeData =
      (ctrl.isLui                  ? uImm      : 32'b0) |
      ((ctrl.isAluImm | ctrl.isAluReg) ? aluOut : 32'b0) |
      (ctrl.isAuipc                ? pcPlusImm : 32'b0) |
      ((ctrl.isJal | ctrl.isJalr)  ? pcPlus4   : 32'b0) |
      (ctrl.isLoad                 ? loadData  : 32'b0);

   // Bus request
   assign memReq.addr       = memAddr;
   assign memReq.writeData  = storeData;
   assign memReq.writeMask  = {4{storeActive}} & storeMask;
   assign memReq.readStrobe = readStrobe;

endmodule

//--- tests/tbMemory.sv
// Word memory model for the core testbench
// Random read and write busy delays, program preload and store capture
module tbMemory (
   input  logic               clk,
   input  coreBusPkg::memReqT memReq,
   output coreBusPkg::memRspT memRsp,
   input  logic               loadProg,
   input  rvIsaPkg::wordT     prog [8],
   output logic               storeSeen,
   output rvIsaPkg::wordT     storeAddr,
   output rvIsaPkg::wordT     storeData,
   output logic [3:0]         storeMask
);
   timeunit 1ns;
   timeprecision 1ps;
   import rvIsaPkg::*;

   wordT        words [256];
   wordT        rdAddr = '0;
   logic [1:0]  rdWait = '0;
   logic [1:0]  wrWait = '0;
   logic [31:0] rng = 32'h3d25;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Background data, every address bit changes the word
   function automatic wordT fillWord(input logic [31:0] idx);
      return 32'h8A5C_F13E ^ (idx * 32'h0101_0101);
   endfunction

   initial storeSeen = 1'b0;

   always @(posedge clk) begin
      storeSeen <= 1'b0;
      if (rdWait != 2'd0) rdWait <= rdWait - 2'd1;
      if (wrWait != 2'd0) wrWait <= wrWait - 2'd1;
      if (loadProg) begin
         // Program at word 0, pattern everywhere else
         for (int i = 0; i < 256; i++) begin
            words[i] <= (i < 8) ? prog[i] : fillWord(i);
         end
         rdWait <= 2'd0;
         wrWait <= 2'd0;
      end else begin
         if (memReq.readStrobe) begin
            rdAddr <= memReq.addr;
            rdWait <= rng[1:0];
         end
         if (memReq.writeMask != 4'b0) begin
            for (int b = 0; b < 4; b++) begin
               if (memReq.writeMask[b]) begin
                  words[memReq.addr[9:2]][8*b +: 8] <= memReq.writeData[8*b +: 8];
               end
            end
            wrWait    <= rng[3:2];
            storeSeen <= 1'b1;
            storeAddr <= memReq.addr;
            storeData <= memReq.writeData;
            storeMask <= memReq.writeMask;
         end
         // New delay draw per transaction
         if (memReq.readStrobe || memReq.writeMask != 4'b0) rng <= xorshift(rng);
      end
   end

   assign memRsp.readData  = words[rdAddr[9:2]];
   assign memRsp.readBusy  = (rdWait != 2'd0);
   assign memRsp.writeBusy = (wrWait != 2'd0);

endmodule

//--- tests/coreTb.sv
// Core testbench
// Table of short programs that each end at their first store
// Result checks, read strobe checks and timeout
module coreTb;
   timeunit 1ns;
   timeprecision 1ps;
   import rvIsaPkg::*;
   import coreBusPkg::*;

   localparam int maxTests = 64;

   logic   clk = 1'b0;
   logic   reset;
   memReqT memReq;
   memRspT memRsp;
   logic   loadProg;
   wordT   prog [8];
   logic   storeSeen;
   wordT   storeAddr;
   wordT   storeData;
   logic [3:0] storeMask;

   // Stimulus table
   string      names [maxTests];
   wordT       progW [maxTests][3];
   wordT       expAddr [maxTests];
   wordT       expData [maxTests];
   logic [3:0] expMask [maxTests];
   int         numTests = 0;
   int         cycles = 0;
   int         cycleLimit = 0;

   // Name of the running test for bus errors
   string      current = "reset";
   logic       lastStrobe = 1'b0;

   femtoCore #(.resetAddr(32'h0), .addrWidth(24)) UUT (
      .clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp)
   );

   tbMemory mem (
      .clk(clk), .memReq(memReq), .memRsp(memRsp), .loadProg(loadProg), .prog(prog),
      .storeSeen(storeSeen), .storeAddr(storeAddr), .storeData(storeData),
      .storeMask(storeMask)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("Test failed");
         $fatal(1, "timeout, no store seen within %0d cycles", cycleLimit);
      end
   end

   // Read strobe lasts one cycle and never comes while a read is busy
   always @(negedge clk) begin
      check({current, " strobe length"}, 32'h0, wordT'(lastStrobe & memReq.readStrobe));
      check({current, " strobe while busy"}, 32'h0,
            wordT'(memRsp.readBusy & memReq.readStrobe));
      lastStrobe <= memReq.readStrobe;
   end

   // RV32I encoders
   function automatic wordT iType(int op, int f3, int rd, int rs1, int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic wordT rType(int f7, int f3, int rd, int rs1, int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic wordT sType(int f3, int rs1, int rs2, int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
   endfunction

   function automatic wordT bType(int f3, int rs1, int rs2, int imm);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic wordT uType(int op, int imm, int rd);
      return {imm[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic wordT jType(int rd, int imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
   endfunction

   function automatic wordT laneBits(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic addTest(string n, wordT w0, wordT w1, wordT w2,
                          wordT a, wordT d, logic [3:0] m);
      names[numTests]    = n;
      progW[numTests][0] = w0;
      progW[numTests][1] = w1;
      progW[numTests][2] = w2;
      expAddr[numTests]  = a;
      expData[numTests]  = d;
      expMask[numTests]  = m;
      numTests++;
   endtask

   // Result left in x4 and stored by the closing word store
   task automatic resultTest(string n, wordT w0, wordT w1, wordT w2, wordT d);
      addTest(n, w0, w1, w2, 32'h100, d, 4'hF);
   endtask

   // Common prelude sets x1 to 0x12345678, x2 to -7 and x3 to 5
   task automatic buildTable();
      wordT nop;
      wordT set1;
      wordT set7;
      nop  = iType(7'h13, 0, 0, 0, 0);
      set1 = iType(7'h13, 0, 4, 0, 1);
      set7 = iType(7'h13, 0, 4, 0, 7);
      resultTest("add",  rType(0, 0, 4, 1, 2), nop, nop, 32'h1234_5671);
      resultTest("sub",  rType(7'h20, 0, 4, 1, 2), nop, nop, 32'h1234_567F);
      resultTest("xor",  rType(0, 4, 4, 1, 2), nop, nop, 32'hEDCB_A981);
      resultTest("or",   rType(0, 6, 4, 1, 2), nop, nop, 32'hFFFF_FFF9);
      resultTest("and",  rType(0, 7, 4, 1, 2), nop, nop, 32'h1234_5678);
      resultTest("slt",  rType(0, 2, 4, 2, 1), nop, nop, 32'h1);
      resultTest("sltu", rType(0, 3, 4, 2, 1), nop, nop, 32'h0);
      resultTest("sll",  rType(0, 1, 4, 1, 3), nop, nop, 32'h468A_CF00);
      resultTest("srl",  rType(0, 5, 4, 2, 3), nop, nop, 32'h07FF_FFFF);
      resultTest("sra",  rType(7'h20, 5, 4, 2, 3), nop, nop, 32'hFFFF_FFFF);
      resultTest("addi",  iType(7'h13, 0, 4, 1, -8), nop, nop, 32'h1234_5670);
      resultTest("xori",  iType(7'h13, 4, 4, 1, 'h0F0), nop, nop, 32'h1234_5688);
      resultTest("ori",   iType(7'h13, 6, 4, 1, 'h701), nop, nop, 32'h1234_5779);
      resultTest("andi",  iType(7'h13, 7, 4, 1, 'h0FF), nop, nop, 32'h78);
      resultTest("slti",  iType(7'h13, 2, 4, 2, -6), nop, nop, 32'h1);
      resultTest("sltiu", iType(7'h13, 3, 4, 1, -1), nop, nop, 32'h1);
      resultTest("slli",  iType(7'h13, 1, 4, 1, 4), nop, nop, 32'h2345_6780);
      resultTest("srli",  iType(7'h13, 5, 4, 1, 8), nop, nop, 32'h0012_3456);
      resultTest("srai",  iType(7'h13, 5, 4, 2, 'h401), nop, nop, 32'hFFFF_FFFC);
      // Upper immediates and jumps with the first test word at PC 16
      resultTest("lui",   uType(7'h37, 'hABCDE, 4), nop, nop, 32'hABCD_E000);
      resultTest("auipc", uType(7'h17, 1, 4), nop, nop, 32'h1010);
      resultTest("jal",   jType(4, 8), set1, nop, 32'h14);
      resultTest("jalr",  iType(7'h67, 0, 4, 3, 23), set1, set1, 32'h14);
      // Taken branches skip to the store and keep 7
      resultTest("beq taken",  set7, bType(0, 3, 3, 8), set1, 32'h7);
      resultTest("beq not",    set7, bType(0, 1, 3, 8), set1, 32'h1);
      resultTest("bne taken",  set7, bType(1, 1, 3, 8), set1, 32'h7);
      resultTest("bne not",    set7, bType(1, 3, 3, 8), set1, 32'h1);
      resultTest("blt taken",  set7, bType(4, 2, 3, 8), set1, 32'h7);
      resultTest("blt not",    set7, bType(4, 3, 2, 8), set1, 32'h1);
      resultTest("bge taken",  set7, bType(5, 3, 2, 8), set1, 32'h7);
      resultTest("bge not",    set7, bType(5, 2, 3, 8), set1, 32'h1);
      resultTest("bltu taken", set7, bType(6, 3, 2, 8), set1, 32'h7);
      resultTest("bltu not",   set7, bType(6, 2, 3, 8), set1, 32'h1);
      resultTest("bgeu taken", set7, bType(7, 2, 3, 8), set1, 32'h7);
      resultTest("bgeu not",   set7, bType(7, 3, 2, 8), set1, 32'h1);
      // Pattern word at 0x100 is 0xCA1CB17E
      resultTest("lb 0",  iType(7'h03, 0, 4, 0, 256), nop, nop, 32'h0000_007E);
      resultTest("lb 1",  iType(7'h03, 0, 4, 0, 257), nop, nop, 32'hFFFF_FFB1);
      resultTest("lb 2",  iType(7'h03, 0, 4, 0, 258), nop, nop, 32'h0000_001C);
      resultTest("lb 3",  iType(7'h03, 0, 4, 0, 259), nop, nop, 32'hFFFF_FFCA);
      resultTest("lbu 0", iType(7'h03, 4, 4, 0, 256), nop, nop, 32'h0000_007E);
      resultTest("lbu 1", iType(7'h03, 4, 4, 0, 257), nop, nop, 32'h0000_00B1);
      resultTest("lbu 2", iType(7'h03, 4, 4, 0, 258), nop, nop, 32'h0000_001C);
      resultTest("lbu 3", iType(7'h03, 4, 4, 0, 259), nop, nop, 32'h0000_00CA);
      resultTest("lh 0",  iType(7'h03, 1, 4, 0, 256), nop, nop, 32'hFFFF_B17E);
      resultTest("lh 2",  iType(7'h03, 1, 4, 0, 258), nop, nop, 32'hFFFF_CA1C);
      resultTest("lhu 0", iType(7'h03, 5, 4, 0, 256), nop, nop, 32'h0000_B17E);
      resultTest("lhu 2", iType(7'h03, 5, 4, 0, 258), nop, nop, 32'h0000_CA1C);
      // Partial stores of x1 with only the masked lanes compared
      addTest("sb 0", sType(0, 0, 1, 256), nop, nop, 32'h100, 32'h0000_0078, 4'b0001);
      addTest("sb 1", sType(0, 0, 1, 257), nop, nop, 32'h101, 32'h0000_7800, 4'b0010);
      addTest("sb 2", sType(0, 0, 1, 258), nop, nop, 32'h102, 32'h0078_0000, 4'b0100);
      addTest("sb 3", sType(0, 0, 1, 259), nop, nop, 32'h103, 32'h7800_0000, 4'b1000);
      addTest("sh 0", sType(1, 0, 1, 256), nop, nop, 32'h100, 32'h0000_5678, 4'b0011);
      addTest("sh 2", sType(1, 0, 1, 258), nop, nop, 32'h102, 32'h5678_0000, 4'b1100);
      addTest("x0 write", iType(7'h13, 0, 0, 0, 5), sType(2, 0, 0, 256), nop,
              32'h100, 32'h0, 4'hF);
   endtask

   task automatic check(string what, wordT expected, wordT actual);
      if (expected !== actual) begin
         $display("error: %s expected %h actual %h", what, expected, actual);
         $display("Test failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   initial begin
      reset    = 1'b0;
      loadProg = 1'b0;
      for (int i = 0; i < 8; i++) begin
         prog[i] = '0;
      end
      buildTable();
      // At most eight instructions of at most ten cycles each per test
      cycleLimit = numTests * 8 * 10;
      for (int t = 0; t < numTests; t++) begin
         @(posedge clk);
         current   = names[t];
         reset    <= 1'b0;
         loadProg <= 1'b1;
         prog[0]  <= uType(7'h37, 'h12345, 1);
         prog[1]  <= iType(7'h13, 0, 1, 1, 'h678);
         prog[2]  <= iType(7'h13, 0, 2, 0, -7);
         prog[3]  <= iType(7'h13, 0, 3, 0, 5);
         prog[4]  <= progW[t][0];
         prog[5]  <= progW[t][1];
         prog[6]  <= progW[t][2];
         prog[7]  <= sType(2, 0, 4, 256);
         @(posedge clk);
         loadProg <= 1'b0;
         repeat (3) @(posedge clk);
         reset <= 1'b1;
         // Stored values sampled away from the active edge
         do begin
            @(negedge clk);
         end while (!storeSeen);
         check({names[t], " addr"}, expAddr[t], storeAddr);
         check({names[t], " mask"}, wordT'(expMask[t]), wordT'(storeMask));
         check({names[t], " data"}, expData[t], storeData & laneBits(expMask[t]));
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- sources.f
common/rvIsaPkg.sv
common/coreBusPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/loadStoreUnit.sv
core/coreSequencer.sv
core/femtoCore.sv
tests/tbMemory.sv
tests/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
